//--- aq_bus_top.sv
`timescale 1ns/1ps

module aq_bus_top #(
    parameter int SYNC_STAGES = 3
) (
    input  logic        clk,
    input  logic        reset,

    // Z80 bus
    input  logic [15:0] addr,
    input  logic [7:0]  d_in,
    input  logic        rd_n,
    input  logic        wr_n,
    input  logic        mreq_n,
    input  logic        iorq_n,
    output logic [7:0]  d_out,
    output logic        d_oe,      // Drive d_out onto the bus

    // External memory
    output logic        ram_ce_n,  // 512 KB RAM
    output logic        cart_ce_n,
    output logic        ram_we_n,
    output logic [4:0]  ba,

    // Keyboard, cassette, printer
    input  logic [63:0] keys,
    input  logic        cassette_in,
    input  logic        printer_in,
    output logic        cassette_out,
    output logic        printer_out,

    output logic        turbo      // To the clock generator
);

    logic            bus_write;
    logic [7:0]      wrdata;
    logic            cassette_sync;
    logic            printer_sync;
    aq_pkg::io_sel_e io_sel;
    logic [7:0]      bank0;
    logic [7:0]      bank1;
    logic [7:0]      bank2;
    logic [7:0]      bank3;
    logic            dis_regs;

    ////////////////////////////////////////////////////////////
    // Bus front end
    ////////////////////////////////////////////////////////////
    bus_sync #(
        .SYNC_STAGES(SYNC_STAGES)
    ) u_bus_sync (
        .clk(clk),
        .reset(reset),
        .rd_n(rd_n),
        .wr_n(wr_n),
        .d_in(d_in),
        .cassette_in(cassette_in),
        .printer_in(printer_in),
        .bus_write(bus_write),
        .wrdata(wrdata),
        .cassette_sync(cassette_sync),
        .printer_sync(printer_sync)
    );

    io_decode u_io_decode (
        .iorq_n(iorq_n),
        .addr_lo(addr[7:0]),
        .dis_regs(dis_regs),
        .io_sel(io_sel)
    );

    ////////////////////////////////////////////////////////////
    // Memory mapping
    ////////////////////////////////////////////////////////////
    mem_map u_mem_map (
        .mreq_n(mreq_n),
        .wr_n(wr_n),
        .addr(addr),
        .bank0(bank0),
        .bank1(bank1),
        .bank2(bank2),
        .bank3(bank3),
        .ram_ce_n(ram_ce_n),
        .cart_ce_n(cart_ce_n),
        .ram_we_n(ram_we_n),
        .ba(ba)
    );

    ////////////////////////////////////////////////////////////
    // Registers and read back
    ////////////////////////////////////////////////////////////
    ctrl_regs u_ctrl_regs (
        .clk(clk),
        .reset(reset),
        .bus_write(bus_write),
        .wrdata(wrdata),
        .io_sel(io_sel),
        .bank0(bank0),
        .bank1(bank1),
        .bank2(bank2),
        .bank3(bank3),
        .dis_regs(dis_regs),
        .turbo(turbo),
        .cassette_out(cassette_out),
        .printer_out(printer_out)
    );

    read_mux u_read_mux (
        .rd_n(rd_n),
        .addr_hi(addr[15:8]),      // Keyboard row select
        .io_sel(io_sel),
        .bank0(bank0),
        .bank1(bank1),
        .bank2(bank2),
        .bank3(bank3),
        .dis_regs(dis_regs),
        .turbo(turbo),
        .cassette_sync(cassette_sync),
        .printer_sync(printer_sync),
        .keys(keys),
        .d_out(d_out),
        .d_oe(d_oe)
    );

endmodule

//--- aq_pkg.sv
package aq_pkg;

    ////////////////////////////////////////////////////////////
    // I/O port map
    ////////////////////////////////////////////////////////////
    localparam logic [7:0] PORT_BANK0    = 8'hF0;
    localparam logic [7:0] PORT_BANK1    = 8'hF1;
    localparam logic [7:0] PORT_BANK2    = 8'hF2;
    localparam logic [7:0] PORT_BANK3    = 8'hF3;
    localparam logic [7:0] PORT_SYSCTRL  = 8'hFB;  // Turbo and register disable
    localparam logic [7:0] PORT_CASSETTE = 8'hFC;
    localparam logic [7:0] PORT_PRINTER  = 8'hFE;
    localparam logic [7:0] PORT_KEYBOARD = 8'hFF;  // Matrix row select on A15..A8

    ////////////////////////////////////////////////////////////
    // External memory pages (16 KB each, 64 in total)
    ////////////////////////////////////////////////////////////
    localparam logic [5:0] PAGE_CART_FIRST = 6'd16;
    localparam logic [5:0] PAGE_CART_LAST  = 6'd19;

    // RAM runs from here to page 63 with system RAM in the first page
    localparam logic [5:0] PAGE_RAM_FIRST  = 6'd32;

    // 2 KB block at the top of a window that shows system RAM when overlay is on
    localparam logic [2:0] SYSRAM_BLOCK    = 3'd7;

    ////////////////////////////////////////////////////////////
    // Bank register layout
    ////////////////////////////////////////////////////////////
    localparam int BANK_RO_BIT      = 7;  // Write protect
    localparam int BANK_OVERLAY_BIT = 6;  // System RAM overlay enable
    localparam int BANK_PAGE_W      = 6;  // Page number field

    // Power-up mapping is page 0 with RO and overlay, RAM pages 33 and 34 and cart page 19
    localparam logic [7:0] BANK0_RESET = 8'hC0;
    localparam logic [7:0] BANK1_RESET = 8'h21;
    localparam logic [7:0] BANK2_RESET = 8'h22;
    localparam logic [7:0] BANK3_RESET = 8'h13;

    ////////////////////////////////////////////////////////////
    // Decoded I/O select
    ////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        IO_NONE,
        IO_BANK0,
        IO_BANK1,
        IO_BANK2,
        IO_BANK3,
        IO_SYSCTRL,
        IO_CASSETTE,
        IO_PRINTER,
        IO_KEYBOARD
    } io_sel_e;

endpackage

//--- bus_sync.sv
`timescale 1ns/1ps

module bus_sync #(
    parameter int SYNC_STAGES = 3  // At least 3
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       rd_n,
    input  logic       wr_n,
    input  logic [7:0] d_in,
    input  logic       cassette_in,
    input  logic       printer_in,
    output logic       bus_write,
    output logic [7:0] wrdata,
    output logic       cassette_sync,
    output logic       printer_sync
);

    logic [SYNC_STAGES-1:0] wr_n_sr;     // Index 0 is the newest sample
    logic [SYNC_STAGES-1:0] cassette_sr;
    logic [SYNC_STAGES-1:0] printer_sr;

    ////////////////////////////////////////////////////////////
    // Write strobe
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_n_sr <= '1;                // Strobe idles high
        end else begin
            wr_n_sr <= {wr_n_sr[SYNC_STAGES-2:0], wr_n};
        end
    end

    // One pulse per falling edge, seen at the two oldest taps
    assign bus_write = wr_n_sr[SYNC_STAGES-1] & ~wr_n_sr[SYNC_STAGES-2];

    // Latch the bus data for as long as the CPU drives it
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wrdata <= 8'h00;
        end else if (!wr_n && rd_n) begin  // Ignore a clash with a read
            wrdata <= d_in;
        end
    end

    ////////////////////////////////////////////////////////////
    // Slow inputs
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cassette_sr <= '0;
            printer_sr  <= '0;
        end else begin
            cassette_sr <= {cassette_sr[SYNC_STAGES-2:0], cassette_in};
            printer_sr  <= {printer_sr[SYNC_STAGES-2:0], printer_in};
        end
    end

    assign cassette_sync = cassette_sr[SYNC_STAGES-1];
    assign printer_sync  = printer_sr[SYNC_STAGES-1];

endmodule

//--- ctrl_regs.sv
`timescale 1ns/1ps

module ctrl_regs (
    input  logic            clk,
    input  logic            reset,
    input  logic            bus_write,
    input  logic [7:0]      wrdata,
    input  aq_pkg::io_sel_e io_sel,
    output logic [7:0]      bank0,
    output logic [7:0]      bank1,
    output logic [7:0]      bank2,
    output logic [7:0]      bank3,
    output logic            dis_regs,
    output logic            turbo,
    output logic            cassette_out,
    output logic            printer_out
);

    ////////////////////////////////////////////////////////////
    // Bank registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bank0 <= aq_pkg::BANK0_RESET;
            bank1 <= aq_pkg::BANK1_RESET;
            bank2 <= aq_pkg::BANK2_RESET;
            bank3 <= aq_pkg::BANK3_RESET;
        end else if (bus_write) begin
            case (io_sel)
                aq_pkg::IO_BANK0: bank0 <= wrdata;
                aq_pkg::IO_BANK1: bank1 <= wrdata;
                aq_pkg::IO_BANK2: bank2 <= wrdata;
                aq_pkg::IO_BANK3: bank3 <= wrdata;
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // System control, cassette and printer
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dis_regs     <= 1'b0;
            turbo        <= 1'b0;
            cassette_out <= 1'b0;
            printer_out  <= 1'b0;
        end else if (bus_write) begin
            case (io_sel)
                aq_pkg::IO_SYSCTRL: begin
                    turbo    <= wrdata[2];  // Bit 1 was the PSG disable
                    dis_regs <= wrdata[0];
                end
                aq_pkg::IO_CASSETTE: begin
                    cassette_out <= wrdata[0];
                end
                aq_pkg::IO_PRINTER: begin
                    printer_out <= wrdata[0];
                end
                default: ;
            endcase
        end
    end

endmodule

//--- io_decode.sv
`timescale 1ns/1ps

module io_decode (
    input  logic            iorq_n,
    input  logic [7:0]      addr_lo,
    input  logic            dis_regs,
    output aq_pkg::io_sel_e io_sel
);

    aq_pkg::io_sel_e port_sel;  // Raw match on the address byte
    logic            is_bank;

    ////////////////////////////////////////////////////////////
    // Address match
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (addr_lo)
            aq_pkg::PORT_BANK0:    port_sel = aq_pkg::IO_BANK0;
            aq_pkg::PORT_BANK1:    port_sel = aq_pkg::IO_BANK1;
            aq_pkg::PORT_BANK2:    port_sel = aq_pkg::IO_BANK2;
            aq_pkg::PORT_BANK3:    port_sel = aq_pkg::IO_BANK3;
            aq_pkg::PORT_SYSCTRL:  port_sel = aq_pkg::IO_SYSCTRL;
            aq_pkg::PORT_CASSETTE: port_sel = aq_pkg::IO_CASSETTE;
            aq_pkg::PORT_PRINTER:  port_sel = aq_pkg::IO_PRINTER;
            aq_pkg::PORT_KEYBOARD: port_sel = aq_pkg::IO_KEYBOARD;
            default:               port_sel = aq_pkg::IO_NONE;
        endcase
    end

    assign is_bank = (port_sel == aq_pkg::IO_BANK0) ||
                     (port_sel == aq_pkg::IO_BANK1) ||
                     (port_sel == aq_pkg::IO_BANK2) ||
                     (port_sel == aq_pkg::IO_BANK3);

    ////////////////////////////////////////////////////////////
    // Qualify with the I/O strobe
    ////////////////////////////////////////////////////////////
    // Bank ports hide behind dis_regs, sysctrl stays open to clear it again
    always_comb begin
        if (iorq_n) begin
            io_sel = aq_pkg::IO_NONE;
        end else if (is_bank && dis_regs) begin
            io_sel = aq_pkg::IO_NONE;
        end else begin
            io_sel = port_sel;
        end
    end

endmodule

//--- mem_map.sv
`timescale 1ns/1ps

module mem_map (
    input  logic        mreq_n,
    input  logic        wr_n,
    input  logic [15:0] addr,
    input  logic [7:0]  bank0,
    input  logic [7:0]  bank1,
    input  logic [7:0]  bank2,
    input  logic [7:0]  bank3,
    output logic        ram_ce_n,
    output logic        cart_ce_n,
    output logic        ram_we_n,
    output logic [4:0]  ba
);

    logic [7:0]                     bank;
    logic [aq_pkg::BANK_PAGE_W-1:0] page;
    logic                           bank_ro;
    logic                           bank_overlay;
    logic                           sysram_hit;
    logic                           allow_mem;
    logic                           sel_cart;
    logic                           sel_ram;

    ////////////////////////////////////////////////////////////
    // Bank register for the current 16 KB window
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (addr[15:14])
            2'd0:    bank = bank0;
            2'd1:    bank = bank1;
            2'd2:    bank = bank2;
            default: bank = bank3;
        endcase
    end

    assign page         = bank[aq_pkg::BANK_PAGE_W-1:0];
    assign bank_ro      = bank[aq_pkg::BANK_RO_BIT];
    assign bank_overlay = bank[aq_pkg::BANK_OVERLAY_BIT];

    // Top 2 KB of the window goes to system RAM when overlay is set
    assign sysram_hit = !mreq_n && bank_overlay && (addr[13:11] == aq_pkg::SYSRAM_BLOCK);

    ////////////////////////////////////////////////////////////
    // Region decode
    ////////////////////////////////////////////////////////////
    // Writes into a read-only bank select nothing
    assign allow_mem = !mreq_n && !sysram_hit && (wr_n || !bank_ro);

    assign sel_cart = allow_mem &&
                      (page >= aq_pkg::PAGE_CART_FIRST) &&
                      (page <= aq_pkg::PAGE_CART_LAST);

    assign sel_ram = (allow_mem && (page >= aq_pkg::PAGE_RAM_FIRST)) || sysram_hit;

    ////////////////////////////////////////////////////////////
    // External chip controls
    ////////////////////////////////////////////////////////////
    assign ram_ce_n  = !sel_ram;
    assign cart_ce_n = !sel_cart;
    assign ram_we_n  = !(!wr_n && (sysram_hit || (sel_ram && !bank_ro)));

    // System RAM lives in page 32, low bits zero
    assign ba = sysram_hit ? 5'd0 : page[4:0];

endmodule

//--- project.f
+incdir+.
aq_pkg.sv
bus_sync.sv
io_decode.sv
mem_map.sv
ctrl_regs.sv
read_mux.sv
aq_bus_top.sv
tb_top.sv

//--- read_mux.sv
`timescale 1ns/1ps

module read_mux (
    input  logic            rd_n,
    input  logic [7:0]      addr_hi,
    input  aq_pkg::io_sel_e io_sel,
    input  logic [7:0]      bank0,
    input  logic [7:0]      bank1,
    input  logic [7:0]      bank2,
    input  logic [7:0]      bank3,
    input  logic            dis_regs,
    input  logic            turbo,
    input  logic            cassette_sync,
    input  logic            printer_sync,
    input  logic [63:0]     keys,
    output logic [7:0]      d_out,
    output logic            d_oe
);

    logic [7:0] key_data;

    ////////////////////////////////////////////////////////////
    // Keyboard matrix scan
    ////////////////////////////////////////////////////////////
    // A low address bit selects its row, keys are active low
    always_comb begin
        key_data = 8'hFF;
        for (int row = 0; row < 8; row++) begin
            if (!addr_hi[row]) begin
                key_data = key_data & keys[row*8 +: 8];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read data
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (io_sel)
            aq_pkg::IO_BANK0:    d_out = bank0;
            aq_pkg::IO_BANK1:    d_out = bank1;
            aq_pkg::IO_BANK2:    d_out = bank2;
            aq_pkg::IO_BANK3:    d_out = bank3;
            aq_pkg::IO_SYSCTRL:  d_out = {5'b0, turbo, 1'b0, dis_regs};
            aq_pkg::IO_CASSETTE: d_out = {7'b0, ~cassette_sync};  // Input is inverted
            aq_pkg::IO_PRINTER:  d_out = {7'b0, printer_sync};
            aq_pkg::IO_KEYBOARD: d_out = key_data;
            default:             d_out = 8'h00;
        endcase
    end

    assign d_oe = !rd_n && (io_sel != aq_pkg::IO_NONE);

endmodule

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_top -f project.f -o tb_top_sim \
    && ./obj_dir/tb_top_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST OK" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

//--- tb_vectors.svh
    vec_t vectors[$];

    task automatic add_vector(input op_e op, input logic [15:0] bus_addr,
                              input logic [7:0] bus_data, input logic [2:0] inputs,
                              input logic [7:0] dout, input logic doe,
                              input logic [2:0] mem, input logic [4:0] bank_addr,
                              input logic [2:0] levels);
        vec_t v;
        v.op         = op;
        v.addr       = bus_addr;
        v.data       = bus_data;
        v.inputs     = inputs;
        v.exp_dout   = dout;
        v.exp_doe    = doe;
        v.exp_mem    = mem;
        v.exp_ba     = bank_addr;
        v.exp_levels = levels;
        vectors.push_back(v);
    endtask

    // Each row holds op, address, data, {cassette_in, printer_in, new keys}, d_out, d_oe,
    // {ram_ce_n, cart_ce_n, ram_we_n}, ba and {turbo, cassette_out, printer_out}
    task automatic load_vectors();
        add_vector(OP_IORD,   16'h00F0, 8'h00, 3'b000, 8'hC0, 1'b1, 3'b111, 5'h00, 3'b000);
        add_vector(OP_IORD,   16'h00F1, 8'h00, 3'b000, 8'h21, 1'b1, 3'b111, 5'h00, 3'b000);
        add_vector(OP_IORD,   16'h00F2, 8'h00, 3'b000, 8'h22, 1'b1, 3'b111, 5'h00, 3'b000);
        add_vector(OP_IORD,   16'h00F3, 8'h00, 3'b000, 8'h13, 1'b1, 3'b111, 5'h00, 3'b000);
        // Window 1 mapped to RAM, cartridge, then nothing
        add_vector(OP_IOWR,   16'h00F1, 8'h28, 3'b000, 8'h00, 1'b0, 3'b111, 5'h00, 3'b000);
        add_vector(OP_MEMRD,  16'h4000, 8'h00, 3'b000, 8'h00, 1'b0, 3'b011, 5'h08, 3'b000);
        add_vector(OP_IOWR,   16'h00F1, 8'h11, 3'b000, 8'h00, 1'b0, 3'b111, 5'h00, 3'b000);
        add_vector(OP_MEMRD,  16'h4000, 8'h00, 3'b000, 8'h00, 1'b0, 3'b101, 5'h11, 3'b000);
        add_vector(OP_IOWR,   16'h00F1, 8'h14, 3'b000, 8'h00, 1'b0, 3'b111, 5'h00, 3'b000);
        add_vector(OP_MEMRD,  16'h4000, 8'h00, 3'b000, 8'h00, 1'b0, 3'b111, 5'h14, 3'b000);
        // Read-only RAM page, then the system RAM overlay in window 0
        add_vector(OP_IOWR,   16'h00F1, 8'hA8, 3'b000, 8'h00, 1'b0, 3'b111, 5'h00, 3'b000);
        add_vector(OP_MEMWR,  16'h4000, 8'h55, 3'b000, 8'h00, 1'b0, 3'b111, 5'h08, 3'b000);
        add_vector(OP_MEMRD,  16'h4000, 8'h00, 3'b000, 8'h00, 1'b0, 3'b011, 5'h08, 3'b000);
        add_vector(OP_MEMWR,  16'h3900, 8'h5A, 3'b000, 8'h00, 1'b0, 3'b010, 5'h00, 3'b000);
        // Overlay over RAM page 40 still drives ba to zero
        add_vector(OP_IOWR,   16'h00F1, 8'h68, 3'b000, 8'h00, 1'b0, 3'b111, 5'h00, 3'b000);
        add_vector(OP_MEMRD,  16'h7800, 8'h00, 3'b000, 8'h00, 1'b0, 3'b011, 5'h00, 3'b000);
        // Turbo and register disable
        add_vector(OP_IOWR,   16'h00FB, 8'h05, 3'b000, 8'h00, 1'b0, 3'b111, 5'h00, 3'b100);
        add_vector(OP_IORD,   16'h00FB, 8'h00, 3'b000, 8'h05, 1'b1, 3'b111, 5'h00, 3'b100);
        add_vector(OP_IORD,   16'h00F0, 8'h00, 3'b000, 8'h00, 1'b0, 3'b111, 5'h00, 3'b100);
        add_vector(OP_IOWR,   16'h00F0, 8'h28, 3'b000, 8'h00, 1'b0, 3'b111, 5'h00, 3'b100);
        add_vector(OP_MEMRD,  16'h0000, 8'h00, 3'b000, 8'h00, 1'b0, 3'b111, 5'h00, 3'b100);
        add_vector(OP_IOWR,   16'h00FB, 8'h00, 3'b000, 8'h00, 1'b0, 3'b111, 5'h00, 3'b000);
        add_vector(OP_IORD,   16'h00F0, 8'h00, 3'b000, 8'hC0, 1'b1, 3'b111, 5'h00, 3'b000);
        // Cassette and printer
        add_vector(OP_IOWR,   16'h00FC, 8'h01, 3'b000, 8'h00, 1'b0, 3'b111, 5'h00, 3'b010);
        add_vector(OP_IOWR,   16'h00FE, 8'h01, 3'b000, 8'h00, 1'b0, 3'b111, 5'h00, 3'b011);
        add_vector(OP_INPUTS, 16'h0000, 8'h00, 3'b010, 8'h00, 1'b0, 3'b111, 5'h00, 3'b011);
        add_vector(OP_IORD,   16'h00FC, 8'h00, 3'b000, 8'h01, 1'b1, 3'b111, 5'h00, 3'b011);
        add_vector(OP_IORD,   16'h00FE, 8'h00, 3'b000, 8'h01, 1'b1, 3'b111, 5'h00, 3'b011);
        // Keyboard rows with d_out worked out from the key pattern
        add_vector(OP_INPUTS, 16'h0000, 8'h00, 3'b011, 8'h00, 1'b0, 3'b111, 5'h00, 3'b011);
        add_vector(OP_IORD,   16'hFEFF, 8'h00, 3'b000, 8'h00, 1'b1, 3'b111, 5'h00, 3'b011);
        add_vector(OP_IORD,   16'h7FFF, 8'h00, 3'b000, 8'h00, 1'b1, 3'b111, 5'h00, 3'b011);
        add_vector(OP_IORD,   16'h00FF, 8'h00, 3'b000, 8'h00, 1'b1, 3'b111, 5'h00, 3'b011);
        add_vector(OP_IORD,   16'hFFFF, 8'h00, 3'b000, 8'h00, 1'b1, 3'b111, 5'h00, 3'b011);
        add_vector(OP_INPUTS, 16'h0000, 8'h00, 3'b011, 8'h00, 1'b0, 3'b111, 5'h00, 3'b011);
        add_vector(OP_IORD,   16'h00FF, 8'h00, 3'b000, 8'h00, 1'b1, 3'b111, 5'h00, 3'b011);
        add_vector(OP_IORD,   16'hA5FF, 8'h00, 3'b000, 8'h00, 1'b1, 3'b111, 5'h00, 3'b011);
    endtask

//--- tb_top.sv
`timescale 1ns/1ps

module tb_top;

    typedef enum logic [2:0] {
        OP_IOWR,
        OP_IORD,
        OP_MEMWR,
        OP_MEMRD,
        OP_INPUTS
    } op_e;

    typedef struct packed {
        op_e         op;
        logic [15:0] addr;
        logic [7:0]  data;
        logic [2:0]  inputs;      // cassette_in, printer_in, new key pattern
        logic [7:0]  exp_dout;
        logic        exp_doe;
        logic [2:0]  exp_mem;     // ram_ce_n, cart_ce_n, ram_we_n
        logic [4:0]  exp_ba;
        logic [2:0]  exp_levels;  // turbo, cassette_out, printer_out
    } vec_t;

    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES  = 4;   // Lets a late write pulse drain

    logic        clk;
    logic        reset;
    logic [15:0] addr;
    logic [7:0]  d_in;
    logic        rd_n;
    logic        wr_n;
    logic        mreq_n;
    logic        iorq_n;
    logic [63:0] keys;
    logic        cassette_in;
    logic        printer_in;
    logic [7:0]  d_out;
    logic        d_oe;
    logic        ram_ce_n;
    logic        cart_ce_n;
    logic        ram_we_n;
    logic [4:0]  ba;
    logic        turbo;
    logic        cassette_out;
    logic        printer_out;

    int seed;
    int vec_index   = 0;
    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    `include "tb_vectors.svh"

    aq_bus_top #(
        .SYNC_STAGES(3)
    ) DUT (
        .clk(clk),
        .reset(reset),
        .addr(addr),
        .d_in(d_in),
        .rd_n(rd_n),
        .wr_n(wr_n),
        .mreq_n(mreq_n),
        .iorq_n(iorq_n),
        .d_out(d_out),
        .d_oe(d_oe),
        .ram_ce_n(ram_ce_n),
        .cart_ce_n(cart_ce_n),
        .ram_we_n(ram_we_n),
        .ba(ba),
        .keys(keys),
        .cassette_in(cassette_in),
        .printer_in(printer_in),
        .cassette_out(cassette_out),
        .printer_out(printer_out),
        .turbo(turbo)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run went past its limit of %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////
    task automatic check_value(input string what, input logic [7:0] actual,
                               input logic [7:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0t ns: vector %0d %s is %h, expected %h",
                     $time, vec_index, what, actual, expected);
        end
    endtask

    // Rows with a low select bit are ANDed, no row gives all ones
    function automatic logic [7:0] expected_keys(input logic [63:0] k, input logic [7:0] sel);
        logic [7:0] result;
        int         row;
        result = 8'hFF;
        for (row = 0; row < 8; row++) begin
            if (sel[row] == 1'b0) begin
                result = result & k[row*8 +: 8];
            end
        end
        return result;
    endfunction

    task automatic check_outputs(input vec_t v);
        logic [7:0] exp_dout;
        exp_dout = v.exp_dout;
        if (v.op == OP_IORD && v.addr[7:0] == 8'hFF) begin
            exp_dout = expected_keys(keys, v.addr[15:8]);
        end
        check_value("d_oe", 8'(d_oe), 8'(v.exp_doe));
        if (v.exp_doe) begin
            check_value("d_out", d_out, exp_dout);
        end
        check_value("ram_ce_n", 8'(ram_ce_n), 8'(v.exp_mem[2]));
        check_value("cart_ce_n", 8'(cart_ce_n), 8'(v.exp_mem[1]));
        check_value("ram_we_n", 8'(ram_we_n), 8'(v.exp_mem[0]));
        if (v.op == OP_MEMRD || v.op == OP_MEMWR) begin
            check_value("ba", 8'(ba), 8'(v.exp_ba));
        end
        check_value("turbo", 8'(turbo), 8'(v.exp_levels[2]));
        check_value("cassette_out", 8'(cassette_out), 8'(v.exp_levels[1]));
        check_value("printer_out", 8'(printer_out), 8'(v.exp_levels[0]));
    endtask

    ////////////////////////////////////////////////////////////
    // Bus cycles
    ////////////////////////////////////////////////////////////
    function automatic int op_cycles(input op_e op);
        case (op)
            OP_IOWR:   return 9 + 1 + IDLE_CYCLES;
            OP_INPUTS: return 7 + 1 + IDLE_CYCLES;
            default:   return 3 + 1 + IDLE_CYCLES;
        endcase
    endfunction

    task automatic apply_vector(input vec_t v);
        @(posedge clk);
        addr <= v.addr;
        d_in <= v.data;
        case (v.op)
            OP_IOWR: begin
                iorq_n <= 1'b0;
                wr_n   <= 1'b0;
            end
            OP_IORD: begin
                iorq_n <= 1'b0;
                rd_n   <= 1'b0;
            end
            OP_MEMWR: begin
                mreq_n <= 1'b0;
                wr_n   <= 1'b0;
            end
            OP_MEMRD: begin
                mreq_n <= 1'b0;
                rd_n   <= 1'b0;
            end
            default: begin
                cassette_in <= v.inputs[2];
                printer_in  <= v.inputs[1];
                if (v.inputs[0]) begin
                    keys <= {$random(seed), $random(seed)};
                end
            end
        endcase
        if (v.op == OP_IOWR) begin
            repeat (6) @(posedge clk);
            wr_n <= 1'b1;                 // Release, then let the register settle
            repeat (2) @(posedge clk);
        end else if (v.op == OP_INPUTS) begin
            repeat (6) @(posedge clk);
        end else begin
            repeat (2) @(posedge clk);
        end
        @(negedge clk);
        check_outputs(v);
        @(posedge clk);
        rd_n   <= 1'b1;
        wr_n   <= 1'b1;
        mreq_n <= 1'b1;
        iorq_n <= 1'b1;
        repeat (IDLE_CYCLES) @(posedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        int total;
        seed        = 32'haa09;
        reset       <= 1'b1;
        addr        <= 16'h0000;
        d_in        <= 8'h00;
        rd_n        <= 1'b1;
        wr_n        <= 1'b1;
        mreq_n      <= 1'b1;
        iorq_n      <= 1'b1;
        keys        <= 64'hFFFF_FFFF_FFFF_FFFF;  // No key down
        cassette_in <= 1'b0;
        printer_in  <= 1'b0;
        load_vectors();
        total = RESET_CYCLES + 1;
        for (int i = 0; i < vectors.size(); i++) begin
            total = total + op_cycles(vectors[i].op);
        end
        cycle_limit = 2 * total;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < vectors.size(); i++) begin
            vec_index = i;
            apply_vector(vectors[i]);
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
